// File: logic/uart_pkg.sv
package uart_pkg;

    // ****************************************
    // frame format
    // ****************************************
    localparam int   DATA_W     = 8;
    localparam int   FRAME_BITS = DATA_W + 2;  // start + data + stop.
    localparam logic START_BIT  = 1'b0;
    localparam logic STOP_BIT   = 1'b1;

    // ****************************************
    // channels
    // ****************************************
    localparam int NUM_CH = 2;

    typedef logic [$clog2(NUM_CH)-1:0] ch_idx_t;

endpackage

// File: logic/flag_sync.sv
`timescale 1ns/1ns

module flag_sync (
    input  logic clk_a,
    input  logic clk_b,
    input  logic rst_n,
    input  logic flag_in,
    output logic flag_out
);

    logic       tgl_a;
    logic [2:0] sync_b;  // two sync stages plus history.

    // source side turns each pulse into a level change.
    always_ff @(posedge clk_a or negedge rst_n) begin
        if (!rst_n) begin
            tgl_a <= 1'b0;
        end else if (flag_in) begin
            tgl_a <= ~tgl_a;
        end
    end

    always_ff @(posedge clk_b or negedge rst_n) begin
        if (!rst_n) begin
            sync_b   <= 3'b000;
            flag_out <= 1'b0;
        end else begin
            sync_b   <= {sync_b[1:0], tgl_a};
            flag_out <= sync_b[2] ^ sync_b[1];  // one pulse per toggle.
        end
    end

    // the toggle must settle on the far side before the next one.
    a_flag_spacing : assert property (
        @(posedge clk_a) disable iff (!rst_n)
        flag_in |=> !flag_in [*3]
    );

endmodule

// File: logic/uart_tx.sv
`timescale 1ns/1ns

module uart_tx #(
    parameter int BAUD     = 115200,
    parameter int UART_CLK = 11059200
) (
    input  logic                        clk_bus,
    input  logic                        clk_uart,
    input  logic                        rst_n,
    input  logic                        rst_uart_n,
    input  logic                        tx_request,
    input  logic [uart_pkg::DATA_W-1:0] data,
    output logic                        idle,
    output logic                        txd
);

    localparam int BAUD_DIV = UART_CLK / BAUD;  // uart cycles per bit.
    localparam int CNT_W    = $clog2(BAUD_DIV + 1);
    localparam int BIT_W    = $clog2(uart_pkg::FRAME_BITS);

    logic                            req_pulse;
    logic                            req_sync;
    logic                            done_pulse;
    logic                            done_sync;
    logic [uart_pkg::DATA_W-1:0]     data_hold;
    logic [uart_pkg::DATA_W-1:0]     data_sync0;
    logic [uart_pkg::DATA_W-1:0]     data_sync1;
    logic [uart_pkg::FRAME_BITS-1:0] frame;
    logic [uart_pkg::FRAME_BITS-2:0] shift_q;
    logic [BIT_W-1:0]                bits_left;
    logic [CNT_W-1:0]                baud_cnt;
    logic                            busy;
    logic                            frame_load;
    logic                            bit_step;

    flag_sync u_sync_req (
        .clk_a    (clk_bus),
        .clk_b    (clk_uart),
        .rst_n    (rst_n),
        .flag_in  (req_pulse),
        .flag_out (req_sync)
    );

    flag_sync u_sync_done (
        .clk_a    (clk_uart),
        .clk_b    (clk_bus),
        .rst_n    (rst_uart_n),
        .flag_in  (done_pulse),
        .flag_out (done_sync)
    );

    // ****************************************
    // bus side
    // ****************************************
    always_ff @(posedge clk_bus or negedge rst_n) begin
        if (!rst_n) begin
            idle      <= 1'b1;
            req_pulse <= 1'b0;
        end else begin
            req_pulse <= 1'b0;
            if (tx_request && idle) begin
                req_pulse <= 1'b1;
                idle      <= 1'b0;
            end else if (done_sync) begin
                idle <= 1'b1;
            end
        end
    end

    // held until done returns.
    always_ff @(posedge clk_bus) begin
        if (tx_request && idle) begin
            data_hold <= data;
        end
    end

    // ****************************************
    // uart side
    // ****************************************
    always_ff @(posedge clk_uart) begin
        data_sync0 <= data_hold;
        data_sync1 <= data_sync0;
    end

    assign frame      = {uart_pkg::STOP_BIT, data_sync1, uart_pkg::START_BIT};
    assign frame_load = !busy && req_sync;
    assign bit_step   = busy && (baud_cnt == '0) && (bits_left != '0);

    always_ff @(posedge clk_uart or negedge rst_uart_n) begin
        if (!rst_uart_n) begin
            busy       <= 1'b0;
            txd        <= 1'b1;
            done_pulse <= 1'b0;
            bits_left  <= '0;
            baud_cnt   <= '0;
        end else begin
            done_pulse <= 1'b0;
            if (frame_load) begin
                busy      <= 1'b1;
                txd       <= frame[0];  // start bit.
                bits_left <= BIT_W'(uart_pkg::FRAME_BITS - 1);
                baud_cnt  <= CNT_W'(BAUD_DIV - 1);
            end else if (busy && baud_cnt != '0) begin
                baud_cnt <= baud_cnt - 1'b1;
            end else if (bit_step) begin
                txd       <= shift_q[0];
                bits_left <= bits_left - 1'b1;
                baud_cnt  <= CNT_W'(BAUD_DIV - 1);
            end else if (busy) begin
                busy       <= 1'b0;  // stop bit served, line stays high.
                done_pulse <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk_uart) begin
        if (frame_load) begin
            shift_q <= frame[uart_pkg::FRAME_BITS-1:1];
        end else if (bit_step) begin
            shift_q <= {uart_pkg::STOP_BIT, shift_q[uart_pkg::FRAME_BITS-2:1]};
        end
    end

    // the arbiter must wait for idle.
    a_req_when_idle : assert property (
        @(posedge clk_bus) disable iff (!rst_n)
        tx_request |-> idle
    );

endmodule

// File: logic/tx_chan_fifo.sv
`timescale 1ns/1ns

module tx_chan_fifo #(
    parameter int FIFO_DEPTH = 4
) (
    input  logic                        clk_bus,
    input  logic                        rst_n,
    input  logic                        req,
    input  logic [uart_pkg::DATA_W-1:0] data,
    output logic                        ack,
    input  logic                        pop,
    output logic                        not_empty,
    output logic [uart_pkg::DATA_W-1:0] head
);

    localparam int   AW      = $clog2(FIFO_DEPTH);
    localparam logic ST_WAIT = 1'b0;
    localparam logic ST_ACK  = 1'b1;

    logic                        state;
    logic                        push;
    logic                        full;
    logic [uart_pkg::DATA_W-1:0] mem [FIFO_DEPTH];
    logic [AW-1:0]               wr_ptr;
    logic [AW-1:0]               rd_ptr;
    logic [AW:0]                 count;

    // ****************************************
    // four-phase handshake
    // ****************************************
    assign push = (state == ST_WAIT) && req && !full;
    assign ack  = (state == ST_ACK);

    always_ff @(posedge clk_bus or negedge rst_n) begin
        if (!rst_n) begin
            state <= ST_WAIT;
        end else if (push) begin
            state <= ST_ACK;
        end else if (state == ST_ACK && !req) begin
            state <= ST_WAIT;  // source released req.
        end
    end

    // ****************************************
    // circular buffer
    // ****************************************
    assign full      = (count == (AW+1)'(FIFO_DEPTH));
    assign not_empty = (count != '0);
    assign head      = mem[rd_ptr];

    always_ff @(posedge clk_bus) begin
        if (push) begin
            mem[wr_ptr] <= data;
        end
    end

    always_ff @(posedge clk_bus or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;  // wraps, depth is a power of two.
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    a_no_pop_empty : assert property (
        @(posedge clk_bus) disable iff (!rst_n)
        pop |-> not_empty
    );

    // occupancy stays within depth and matches the pointers.
    a_no_push_full : assert property (
        @(posedge clk_bus) disable iff (!rst_n)
        (count <= (AW+1)'(FIFO_DEPTH)) && (wr_ptr == rd_ptr + count[AW-1:0])
    );

endmodule

// File: logic/tx_arbiter.sv
`timescale 1ns/1ns

module tx_arbiter (
    input  logic                        clk_bus,
    input  logic                        rst_n,
    input  logic [uart_pkg::NUM_CH-1:0] ch_not_empty,
    input  logic [uart_pkg::DATA_W-1:0] ch0_head,
    input  logic [uart_pkg::DATA_W-1:0] ch1_head,
    output logic [uart_pkg::NUM_CH-1:0] ch_pop,
    input  logic                        idle,
    output logic                        tx_request,
    output logic [uart_pkg::DATA_W-1:0] tx_data
);

    uart_pkg::ch_idx_t last_served;
    uart_pkg::ch_idx_t next_ch;
    uart_pkg::ch_idx_t grant;
    logic              issue;

    // ****************************************
    // round-robin pick
    // ****************************************
    assign next_ch = last_served + 1'b1;
    assign grant   = ch_not_empty[next_ch] ? next_ch : last_served;
    assign issue   = idle && (|ch_not_empty);

    assign tx_request = issue;
    assign ch_pop     = issue ? (uart_pkg::NUM_CH'(1) << grant) : '0;
    assign tx_data    = (grant == uart_pkg::ch_idx_t'(1)) ? ch1_head : ch0_head;

    always_ff @(posedge clk_bus or negedge rst_n) begin
        if (!rst_n) begin
            last_served <= uart_pkg::ch_idx_t'(uart_pkg::NUM_CH - 1);  // ch0 first.
        end else if (issue) begin
            last_served <= grant;
        end
    end

    // with both channels waiting, the last served one is skipped.
    a_rr_alternate : assert property (
        @(posedge clk_bus) disable iff (!rst_n)
        tx_request && (&ch_not_empty) |-> !ch_pop[last_served]
    );

endmodule

// File: logic/uart_top.sv
`timescale 1ns/1ns

module uart_top #(
    parameter int BAUD       = 115200,
    parameter int UART_CLK   = 11059200,
    parameter int FIFO_DEPTH = 4
) (
    input  logic                        clk_bus,
    input  logic                        clk_uart,
    input  logic                        rst_n,
    input  logic                        rst_uart_n,
    input  logic                        ch0_req,
    input  logic [uart_pkg::DATA_W-1:0] ch0_data,
    output logic                        ch0_ack,
    input  logic                        ch1_req,
    input  logic [uart_pkg::DATA_W-1:0] ch1_data,
    output logic                        ch1_ack,
    output logic                        txd,
    output logic                        idle
);

    localparam uart_pkg::ch_idx_t CH0 = 1'b0;
    localparam uart_pkg::ch_idx_t CH1 = 1'b1;

    logic [uart_pkg::NUM_CH-1:0] ch_not_empty;
    logic [uart_pkg::NUM_CH-1:0] ch_pop;
    logic [uart_pkg::DATA_W-1:0] ch0_head;
    logic [uart_pkg::DATA_W-1:0] ch1_head;
    logic                        tx_request;
    logic [uart_pkg::DATA_W-1:0] tx_data;

    tx_chan_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_chan0 (
        .clk_bus   (clk_bus),
        .rst_n     (rst_n),
        .req       (ch0_req),
        .data      (ch0_data),
        .ack       (ch0_ack),
        .pop       (ch_pop[CH0]),
        .not_empty (ch_not_empty[CH0]),
        .head      (ch0_head)
    );

    tx_chan_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_chan1 (
        .clk_bus   (clk_bus),
        .rst_n     (rst_n),
        .req       (ch1_req),
        .data      (ch1_data),
        .ack       (ch1_ack),
        .pop       (ch_pop[CH1]),
        .not_empty (ch_not_empty[CH1]),
        .head      (ch1_head)
    );

    tx_arbiter u_arbiter (
        .clk_bus      (clk_bus),
        .rst_n        (rst_n),
        .ch_not_empty (ch_not_empty),
        .ch0_head     (ch0_head),
        .ch1_head     (ch1_head),
        .ch_pop       (ch_pop),
        .idle         (idle),
        .tx_request   (tx_request),
        .tx_data      (tx_data)
    );

    uart_tx #(
        .BAUD     (BAUD),
        .UART_CLK (UART_CLK)
    ) u_uart_tx (
        .clk_bus    (clk_bus),
        .clk_uart   (clk_uart),
        .rst_n      (rst_n),
        .rst_uart_n (rst_uart_n),
        .tx_request (tx_request),
        .data       (tx_data),
        .idle       (idle),
        .txd        (txd)
    );

endmodule

// File: sim/tb_clock_gen.sv
`timescale 1ns/1ns

module tb_clock_gen #(
    parameter int BUS_PERIOD  = 40,
    parameter int UART_PERIOD = 24,
    parameter int RST_CYCLES  = 16
) (
    output logic clk_bus,
    output logic clk_uart,
    output logic rst_n,
    output logic rst_uart_n
);

    initial begin
        clk_bus = 1'b0;
        forever #(BUS_PERIOD / 2) clk_bus = ~clk_bus;
    end

    initial begin
        clk_uart = 1'b0;
        #7;  // phase offset against the bus clock.
        forever #(UART_PERIOD / 2) clk_uart = ~clk_uart;
    end

    initial begin
        rst_n      = 1'b0;
        rst_uart_n = 1'b0;
        repeat (RST_CYCLES) @(posedge clk_bus);
        rst_n      <= 1'b1;
        rst_uart_n <= 1'b1;
    end

endmodule

// File: sim/tb_uart_top.sv
`timescale 1ns/1ns

module tb_uart_top;

    localparam int BAUD        = 115200;
    localparam int UART_CLK    = 921600;
    localparam int FIFO_DEPTH  = 4;
    localparam int BAUD_DIV    = UART_CLK / BAUD;  // uart cycles per bit.
    localparam int BUS_PERIOD  = 40;
    localparam int UART_PERIOD = 24;
    localparam int RST_CYCLES  = 16;
    localparam int MAX_GAP     = 8;
    localparam int IDLE_WAIT   = 16;  // done crossing, in bus cycles.
    localparam int FRAME_NS    = uart_pkg::FRAME_BITS * BAUD_DIV * UART_PERIOD;
    localparam int NUM_ROWS    = 26;
    localparam int WATCHDOG_NS = NUM_ROWS * (FRAME_NS + MAX_GAP * BUS_PERIOD) * 2
                                 + RST_CYCLES * BUS_PERIOD;

    // columns: test, channel, byte, gap in cycles (ff means a random gap).
    localparam logic [31:0] STIM [NUM_ROWS] = '{
        32'h02_00_41_00,
        32'h03_00_10_ff, 32'h03_01_90_ff, 32'h03_00_11_ff, 32'h03_01_91_ff,
        32'h03_00_12_ff, 32'h03_01_92_ff, 32'h03_00_13_ff, 32'h03_01_93_ff,
        32'h04_01_a0_00, 32'h04_01_a1_00, 32'h04_01_a2_00, 32'h04_01_a3_00,
        32'h04_01_a4_00, 32'h04_01_a5_00, 32'h04_01_a6_00,
        32'h06_00_20_00, 32'h06_01_c0_00, 32'h06_00_21_00, 32'h06_01_c1_00,
        32'h06_00_22_00, 32'h06_01_c2_00, 32'h06_00_23_00, 32'h06_01_c3_00,
        32'h06_00_24_00, 32'h06_01_c4_00
    };

    logic                        clk_bus;
    logic                        clk_uart;
    logic                        rst_n;
    logic                        rst_uart_n;
    logic                        ch0_req;
    logic [uart_pkg::DATA_W-1:0] ch0_data;
    logic                        ch0_ack;
    logic                        ch1_req;
    logic [uart_pkg::DATA_W-1:0] ch1_data;
    logic                        ch1_ack;
    logic                        txd;
    logic                        idle;

    logic [uart_pkg::DATA_W-1:0] exp0_q[$];
    logic [uart_pkg::DATA_W-1:0] exp1_q[$];
    logic [uart_pkg::DATA_W-1:0] rx0_q[$];
    logic [uart_pkg::DATA_W-1:0] rx1_q[$];
    logic                        rx_order[$];  // source channel of each frame.
    logic                        stall_seen;
    logic                        ch0_req_q;
    logic                        ch0_ack_q;
    logic                        ch1_req_q;
    logic                        ch1_ack_q;
    int                          err_cnt = 0;
    int                          hs_err_cnt = 0;
    int                          tests_failed = 0;
    int                          errs_at_start = 0;

    tb_clock_gen #(
        .BUS_PERIOD  (BUS_PERIOD),
        .UART_PERIOD (UART_PERIOD),
        .RST_CYCLES  (RST_CYCLES)
    ) u_clock_gen (
        .clk_bus    (clk_bus),
        .clk_uart   (clk_uart),
        .rst_n      (rst_n),
        .rst_uart_n (rst_uart_n)
    );

    uart_top #(
        .BAUD       (BAUD),
        .UART_CLK   (UART_CLK),
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_uart_top (
        .clk_bus    (clk_bus),
        .clk_uart   (clk_uart),
        .rst_n      (rst_n),
        .rst_uart_n (rst_uart_n),
        .ch0_req    (ch0_req),
        .ch0_data   (ch0_data),
        .ch0_ack    (ch0_ack),
        .ch1_req    (ch1_req),
        .ch1_data   (ch1_data),
        .ch1_ack    (ch1_ack),
        .txd        (txd),
        .idle       (idle)
    );

    // ****************************************
    // helpers
    // ****************************************
    task automatic report_mismatch(input string name, input logic [31:0] expected,
                                   input logic [31:0] actual);
        err_cnt++;
        $display("Fail at %0t ns: %s expected %0h got %0h", $time, name, expected, actual);
    endtask

    function automatic logic ack_of(input int ch);
        return (ch == 0) ? ch0_ack : ch1_ack;
    endfunction

    task automatic set_request(input int ch, input logic req,
                               input logic [uart_pkg::DATA_W-1:0] b);
        if (ch == 0) begin
            ch0_req  <= req;
            ch0_data <= b;
        end else begin
            ch1_req  <= req;
            ch1_data <= b;
        end
    endtask

    // one four-phase transfer, entered right after a rising edge.
    task automatic send_byte(input int ch, input logic [uart_pkg::DATA_W-1:0] b);
        int waited;
        waited = 0;
        set_request(ch, 1'b1, b);
        do begin
            @(posedge clk_bus);
            waited++;
        end while (!ack_of(ch));
        if (waited > 2) begin
            stall_seen = 1'b1;  // held off by a full fifo.
        end
        if (ch == 0) begin
            exp0_q.push_back(b);
        end else begin
            exp1_q.push_back(b);
        end
        set_request(ch, 1'b0, b);
        do begin
            @(posedge clk_bus);
        end while (ack_of(ch));
    endtask

    task automatic run_channel(input int test_id, input int ch);
        int gap;
        @(posedge clk_bus);
        for (int i = 0; i < NUM_ROWS; i++) begin
            if (STIM[i][31:24] == test_id && STIM[i][23:16] == ch) begin
                gap = (STIM[i][7:0] == 8'hff) ? int'($urandom % MAX_GAP)
                                              : int'(STIM[i][7:0]);
                repeat (gap) @(posedge clk_bus);
                send_byte(ch, STIM[i][15:8]);
            end
        end
    endtask

    task automatic compare_channel(input string name,
                                   input logic [uart_pkg::DATA_W-1:0] exp_q[$],
                                   input logic [uart_pkg::DATA_W-1:0] got_q[$]);
        if (got_q.size() != exp_q.size()) begin
            report_mismatch({name, " frame count"}, exp_q.size(), got_q.size());
        end else begin
            foreach (exp_q[i]) begin
                if (got_q[i] !== exp_q[i]) begin
                    report_mismatch({name, " byte on txd"}, exp_q[i], got_q[i]);
                end
            end
        end
    endtask

    task automatic run_table(input int test_id);
        int waited;
        rx_order.delete();
        stall_seen = 1'b0;
        fork
            run_channel(test_id, 0);
            run_channel(test_id, 1);
        join
        while (rx0_q.size() < exp0_q.size() || rx1_q.size() < exp1_q.size()) begin
            @(posedge clk_bus);
        end
        waited = 0;
        while (idle !== 1'b1 && waited < IDLE_WAIT) begin
            @(posedge clk_bus);
            waited++;
        end
        if (idle !== 1'b1) begin
            err_cnt++;
            $display("Error at %0t ns: idle did not return after the last frame", $time);
        end
        compare_channel("ch0", exp0_q, rx0_q);
        compare_channel("ch1", exp1_q, rx1_q);
        exp0_q.delete();
        exp1_q.delete();
        rx0_q.delete();
        rx1_q.delete();
    endtask

    task automatic finish_test(input int test_id, input string name);
        if (err_cnt == errs_at_start) begin
            $display("test %0d %s: passed", test_id, name);
        end else begin
            $display("test %0d %s: FAILED, %0d errors", test_id, name, err_cnt - errs_at_start);
            tests_failed++;
        end
        errs_at_start = err_cnt;
    endtask

    // ****************************************
    // serial line decoder
    // ****************************************
    initial begin : txd_decoder
        logic [uart_pkg::DATA_W-1:0] rx_byte;
        logic                        last_txd;
        logic                        start_val;
        logic                        stop_val;
        int                          idx;
        rx_byte   = '0;
        start_val = 1'b0;
        stop_val  = 1'b1;
        forever begin
            @(posedge clk_uart);
            if (rst_uart_n === 1'b1 && txd === uart_pkg::START_BIT) begin
                last_txd = txd;
                for (int k = 1; k < uart_pkg::FRAME_BITS * BAUD_DIV; k++) begin
                    @(posedge clk_uart);
                    if (txd !== last_txd && k % BAUD_DIV != 0) begin
                        err_cnt++;
                        $display("Error at %0t ns: txd changed %0d uart cycles into a frame",
                                 $time, k);
                    end
                    last_txd = txd;
                    if (k % BAUD_DIV == BAUD_DIV / 2) begin  // mid-bit.
                        idx = k / BAUD_DIV;
                        if (idx == 0) begin
                            start_val = txd;
                        end else if (idx == uart_pkg::FRAME_BITS - 1) begin
                            stop_val = txd;
                        end else begin
                            rx_byte[idx-1] = txd;  // lsb first.
                        end
                    end
                end
                if (start_val !== uart_pkg::START_BIT) begin
                    report_mismatch("txd start bit", uart_pkg::START_BIT, start_val);
                end
                if (stop_val !== uart_pkg::STOP_BIT) begin
                    report_mismatch("txd stop bit", uart_pkg::STOP_BIT, stop_val);
                end
                if (rx_byte < 8'h80) begin
                    rx0_q.push_back(rx_byte);
                end else begin
                    rx1_q.push_back(rx_byte);
                end
                rx_order.push_back(rx_byte[7]);
            end
        end
    end

    // four-phase rule at the DUT ports.
    always @(posedge clk_bus) begin
        if (rst_n === 1'b1) begin
            if ((ch0_ack && !ch0_ack_q && !ch0_req_q) ||
                (ch1_ack && !ch1_ack_q && !ch1_req_q)) begin
                hs_err_cnt++;
                $display("Error at %0t ns: ack rose while req was low", $time);
            end
            if ((!ch0_ack && ch0_ack_q && ch0_req_q) ||
                (!ch1_ack && ch1_ack_q && ch1_req_q)) begin
                hs_err_cnt++;
                $display("Error at %0t ns: ack fell while req was still high", $time);
            end
        end
        ch0_req_q = ch0_req;
        ch0_ack_q = ch0_ack;
        ch1_req_q = ch1_req;
        ch1_ack_q = ch1_ack;
    end

    initial begin : watchdog
        #(WATCHDOG_NS);
        $display("Timeout: the run did not finish within %0d ns", WATCHDOG_NS);
        $display("Something failed");
        $finish;
    end

    // ****************************************
    // test sequence
    // ****************************************
    initial begin : main_seq
        ch0_req  = 1'b0;
        ch0_data = '0;
        ch1_req  = 1'b0;
        ch1_data = '0;
        void'($urandom(32'h3006));
        wait (rst_n === 1'b1);
        @(posedge clk_bus);

        if (txd !== 1'b1) report_mismatch("txd", 1, txd);
        if (idle !== 1'b1) report_mismatch("idle", 1, idle);
        if (ch0_ack !== 1'b0) report_mismatch("ch0_ack", 0, ch0_ack);
        if (ch1_ack !== 1'b0) report_mismatch("ch1_ack", 0, ch1_ack);
        finish_test(1, "reset values");

        run_table(2);
        if (rx_order.size() != 1) report_mismatch("frame count", 1, rx_order.size());
        finish_test(2, "single byte");

        run_table(3);
        finish_test(3, "interleaved order");

        run_table(4);
        if (!stall_seen) begin
            err_cnt++;
            $display("Error: no request on ch1 was held off by a full FIFO");
        end
        finish_test(4, "back-pressure");

        run_table(6);
        for (int i = 1; i < rx_order.size(); i++) begin
            if (rx_order[i] == rx_order[i-1]) begin
                err_cnt++;
                $display("Error: frame %0d came from the same channel as the frame before", i);
            end
        end
        finish_test(6, "fairness");

        if (hs_err_cnt == 0) begin
            $display("test 5 four-phase rule: passed");
        end else begin
            $display("test 5 four-phase rule: FAILED, %0d errors", hs_err_cnt);
            tests_failed++;
        end

        $display("tests run: 6, failed: %0d, errors: %0d", tests_failed, err_cnt + hs_err_cnt);
        if (tests_failed == 0 && err_cnt + hs_err_cnt == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

// File: src.f
logic/uart_pkg.sv
logic/flag_sync.sv
logic/uart_tx.sv
logic/tx_chan_fifo.sv
logic/tx_arbiter.sv
logic/uart_top.sv
sim/tb_clock_gen.sv
sim/tb_uart_top.sv

// File: Bender.yml
package:
  name: uart_top

sources:
  - logic/uart_pkg.sv
  - logic/flag_sync.sv
  - logic/uart_tx.sv
  - logic/tx_chan_fifo.sv
  - logic/tx_arbiter.sv
  - logic/uart_top.sv
  - target: simulation
    files:
      - sim/tb_clock_gen.sv
      - sim/tb_uart_top.sv
